//--- ofm_pkg.sv
`default_nettype none

package ofm_pkg;

   // ------------------------------------------------
   // tile geometry
   // ------------------------------------------------
   localparam int DATA_W    = 16;  // one feature map word
   localparam int TN        = 4;   // output channels per tile
   localparam int TR        = 4;   // rows per tile
   localparam int TC        = 4;   // columns per tile

   // one channel slice lives in one bank
   localparam int NUM_BANKS   = TN;
   localparam int SLICE_WORDS = TR * TC;
   localparam int TILE_WORDS  = TN * SLICE_WORDS;

   localparam int ADDR_W = 4;  // word address inside a bank
   localparam int BANK_W = 2;  // bank number

   // tile word counter, wraps after the last word of the tile
   localparam int CNT_W = $clog2(TILE_WORDS);

   // ------------------------------------------------
   // compute engine request
   // ------------------------------------------------
   // acc and rd are single-cycle strobes, at most one of them is
   // expected per cycle; bank picks the target slice
   typedef struct packed {
      logic              acc;   // add data to the addressed word
      logic              rd;    // read the addressed word
      logic [BANK_W-1:0] bank;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;  // value to add
   } ofm_pe_req_t;

endpackage

`default_nettype wire

//--- ofm_load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_load_ctrl (
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             ld_start,
   input  wire                             tile_clean,
   input  wire                             ld_fifo_empty,
   input  wire  [ofm_pkg::DATA_W-1:0]      ld_fifo_data,
   output logic                            ld_fifo_pop,
   output logic                            ld_done,
   output logic [ofm_pkg::NUM_BANKS-1:0]   wr_ena,
   output logic [ofm_pkg::ADDR_W-1:0]      wr_addr,
   output logic [ofm_pkg::DATA_W-1:0]      wr_data
);
   import ofm_pkg::*;

   logic                 running;
   logic [CNT_W-1:0]     tile_cnt;   // pops issued in this tile
   logic [ADDR_W-1:0]    slice_cnt;  // word address inside current slice
   logic [NUM_BANKS-1:0] bank_sel;   // one-hot, slice being filled
   logic                 slice_wrap;
   logic                 tile_last;

   // stage matching the one-cycle FIFO read latency
   logic                 pop_q;
   logic [ADDR_W-1:0]    addr_q;
   logic [NUM_BANKS-1:0] sel_q;

   // never pops an empty FIFO, done gates the 65th pop
   assign ld_fifo_pop = running && !ld_fifo_empty && !ld_done;

   assign slice_wrap = ld_fifo_pop && (slice_cnt == ADDR_W'(SLICE_WORDS - 1));
   assign tile_last  = ld_fifo_pop && (tile_cnt == CNT_W'(TILE_WORDS - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running <= 1'b0;
         ld_done <= 1'b0;
      end else if (tile_clean) begin
         running <= 1'b0;
         ld_done <= 1'b0;
      end else begin
         if (ld_start)
            running <= 1'b1;
         else if (tile_last)
            running <= 1'b0;
         if (tile_last)
            ld_done <= 1'b1;  // level, held until tile_clean
      end
   end

   // ------------------------------------------------
   // word counters and slice rotation
   // ------------------------------------------------
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tile_cnt  <= '0;
         slice_cnt <= '0;
         bank_sel  <= NUM_BANKS'(1);
      end else if (tile_clean) begin
         tile_cnt  <= '0;
         slice_cnt <= '0;
         bank_sel  <= NUM_BANKS'(1);
      end else if (ld_fifo_pop) begin
         tile_cnt  <= tile_cnt + 1'b1;
         slice_cnt <= slice_cnt + 1'b1;  // wraps at slice end
         if (slice_wrap)
            bank_sel <= {bank_sel[NUM_BANKS-2:0], bank_sel[NUM_BANKS-1]};
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pop_q  <= 1'b0;
         addr_q <= '0;
         sel_q  <= '0;
      end else begin
         pop_q  <= ld_fifo_pop;
         addr_q <= slice_cnt;
         sel_q  <= bank_sel;
      end
   end

   // popped word is on ld_fifo_data now, written at the next edge
   assign wr_ena  = sel_q & {NUM_BANKS{pop_q}};
   assign wr_addr = addr_q;
   assign wr_data = ld_fifo_data;

endmodule

`default_nettype wire

//--- ofm_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_bank (
   input  wire                          clk,
   input  wire                          rst,
   // load write port
   input  wire                          wr_ena,
   input  wire  [ofm_pkg::ADDR_W-1:0]   wr_addr,
   input  wire  [ofm_pkg::DATA_W-1:0]   wr_data,
   // store read port
   input  wire                          rd_ena,
   input  wire  [ofm_pkg::ADDR_W-1:0]   rd_addr,
   output logic [ofm_pkg::DATA_W-1:0]   rd_data,
   // compute port, strobes already masked for this bank
   input  wire                          pe_acc,
   input  wire                          pe_rd,
   input  wire  [ofm_pkg::ADDR_W-1:0]   pe_addr,
   input  wire  [ofm_pkg::DATA_W-1:0]   pe_data,
   output logic [ofm_pkg::DATA_W-1:0]   pe_rd_data
);
   import ofm_pkg::*;

   logic [DATA_W-1:0] mem [SLICE_WORDS];
   logic [DATA_W-1:0] acc_sum;

   // partial sum, wraps on overflow
   assign acc_sum = mem[pe_addr] + pe_data;

   // ------------------------------------------------
   // slice storage
   // ------------------------------------------------
   // load and accumulate are never active in the same cycle,
   // the outside controller sequences the phases
   always_ff @(posedge clk) begin
      if (wr_ena)
         mem[wr_addr] <= wr_data;
      else if (pe_acc)
         mem[pe_addr] <= acc_sum;  // read-modify-write in one cycle
   end

   // ------------------------------------------------
   // registered reads
   // ------------------------------------------------
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         rd_data <= '0;
      else if (rd_ena)
         rd_data <= mem[rd_addr];  // store side
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         pe_rd_data <= '0;
      else if (pe_rd)
         pe_rd_data <= mem[pe_addr];  // compute side
   end

endmodule

`default_nettype wire

//--- ofm_store_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_store_ctrl (
   input  wire                                                 clk,
   input  wire                                                 rst,
   input  wire                                                 st_start,
   input  wire                                                 tile_clean,
   input  wire                                                 st_fifo_almost_full,
   input  wire  [ofm_pkg::NUM_BANKS-1:0][ofm_pkg::DATA_W-1:0]  bank_rd_data,
   output logic [ofm_pkg::NUM_BANKS-1:0]                       rd_ena,
   output logic [ofm_pkg::ADDR_W-1:0]                          rd_addr,
   output logic                                                st_fifo_push,
   output logic [ofm_pkg::DATA_W-1:0]                          st_fifo_data,
   output logic                                                st_done
);
   import ofm_pkg::*;

   logic                 running;
   logic                 issue;      // read request this cycle
   logic [CNT_W-1:0]     tile_cnt;
   logic [ADDR_W-1:0]    slice_cnt;
   logic [NUM_BANKS-1:0] bank_sel;
   logic                 slice_wrap;
   logic                 tile_last;

   // stage 1, registered issue towards the banks
   logic                 issue_q;
   logic [ADDR_W-1:0]    addr_q;
   logic [NUM_BANKS-1:0] sel_q;

   // stage 2, bank output register holds the word
   logic [NUM_BANKS-1:0] sel_d2;

   // almost full stops new issues at once, two may still be in flight
   assign issue = running && !st_fifo_almost_full && !st_done;

   assign slice_wrap = issue && (slice_cnt == ADDR_W'(SLICE_WORDS - 1));
   assign tile_last  = issue && (tile_cnt == CNT_W'(TILE_WORDS - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running <= 1'b0;
         st_done <= 1'b0;
      end else if (tile_clean) begin
         running <= 1'b0;
         st_done <= 1'b0;
      end else begin
         if (st_start)
            running <= 1'b1;
         else if (tile_last)
            running <= 1'b0;
         if (tile_last)
            st_done <= 1'b1;
      end
   end

   // ------------------------------------------------
   // read order, same slice order as the load side
   // ------------------------------------------------
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tile_cnt  <= '0;
         slice_cnt <= '0;
         bank_sel  <= NUM_BANKS'(1);
      end else if (tile_clean) begin
         tile_cnt  <= '0;
         slice_cnt <= '0;
         bank_sel  <= NUM_BANKS'(1);
      end else if (issue) begin
         tile_cnt  <= tile_cnt + 1'b1;
         slice_cnt <= slice_cnt + 1'b1;
         if (slice_wrap)
            bank_sel <= {bank_sel[NUM_BANKS-2:0], bank_sel[NUM_BANKS-1]};
      end
   end

   // ------------------------------------------------
   // two-stage pipeline to the store FIFO
   // ------------------------------------------------
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         issue_q      <= 1'b0;
         addr_q       <= '0;
         sel_q        <= '0;
         st_fifo_push <= 1'b0;
         sel_d2       <= '0;
      end else begin
         issue_q      <= issue;
         addr_q       <= slice_cnt;
         sel_q        <= bank_sel;
         st_fifo_push <= issue_q;  // lines up with bank rd_data
         sel_d2       <= sel_q;
      end
   end

   assign rd_ena  = sel_q & {NUM_BANKS{issue_q}};
   assign rd_addr = addr_q;

   // one-hot mux over the bank outputs
   always_comb begin
      st_fifo_data = '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         if (sel_d2[i])
            st_fifo_data = bank_rd_data[i];
      end
   end

endmodule

`default_nettype wire

//--- ofm_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_buffer (
   input  wire                          clk,
   input  wire                          rst,
   // load FIFO
   input  wire  [ofm_pkg::DATA_W-1:0]   ld_fifo_data,
   input  wire                          ld_fifo_empty,
   output logic                         ld_fifo_pop,
   // store FIFO
   output logic [ofm_pkg::DATA_W-1:0]   st_fifo_data,
   output logic                         st_fifo_push,
   input  wire                          st_fifo_almost_full,
   // control
   input  wire                          ld_start,
   input  wire                          st_start,
   input  wire                          tile_clean,
   input  wire                          compute_start,
   output logic                         ld_done,
   output logic                         st_done,
   output logic                         compute_on_going,
   // compute engine
   input  wire  ofm_pkg::ofm_pe_req_t   pe_req,
   output logic [ofm_pkg::DATA_W-1:0]   pe_rd_data
);
   import ofm_pkg::*;

   logic [NUM_BANKS-1:0]             wr_ena;
   logic [ADDR_W-1:0]                wr_addr;
   logic [DATA_W-1:0]                wr_data;
   logic [NUM_BANKS-1:0]             rd_ena;
   logic [ADDR_W-1:0]                rd_addr;
   logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rd_data;
   logic [NUM_BANKS-1:0][DATA_W-1:0] bank_pe_rd_data;
   logic [NUM_BANKS-1:0]             pe_acc;   // per-bank strobes
   logic [NUM_BANKS-1:0]             pe_rd;
   logic [BANK_W-1:0]                pe_bank_q;

   // compute phase flag, a load or store start ends it
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         compute_on_going <= 1'b0;
      else if (ld_start || st_start)
         compute_on_going <= 1'b0;
      else if (compute_start)
         compute_on_going <= 1'b1;
   end

   // remembers which bank answers the pending read
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         pe_bank_q <= '0;
      else if (pe_req.rd)
         pe_bank_q <= pe_req.bank;
   end

   assign pe_rd_data = bank_pe_rd_data[pe_bank_q];

   ofm_load_ctrl load_ctrl_inst (
      .clk           (clk),
      .rst           (rst),
      .ld_start      (ld_start),
      .tile_clean    (tile_clean),
      .ld_fifo_empty (ld_fifo_empty),
      .ld_fifo_data  (ld_fifo_data),
      .ld_fifo_pop   (ld_fifo_pop),
      .ld_done       (ld_done),
      .wr_ena        (wr_ena),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data)
   );

   // ------------------------------------------------
   // banks, one channel slice each
   // ------------------------------------------------
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      // bank decode happens here, strobes ignored outside compute
      assign pe_acc[i] = compute_on_going && pe_req.acc && (pe_req.bank == BANK_W'(i));
      assign pe_rd[i]  = compute_on_going && pe_req.rd && (pe_req.bank == BANK_W'(i));

      ofm_bank bank_inst (
         .clk        (clk),
         .rst        (rst),
         .wr_ena     (wr_ena[i]),
         .wr_addr    (wr_addr),
         .wr_data    (wr_data),
         .rd_ena     (rd_ena[i]),
         .rd_addr    (rd_addr),
         .rd_data    (bank_rd_data[i]),
         .pe_acc     (pe_acc[i]),
         .pe_rd      (pe_rd[i]),
         .pe_addr    (pe_req.addr),
         .pe_data    (pe_req.data),
         .pe_rd_data (bank_pe_rd_data[i])
      );
   end

   ofm_store_ctrl store_ctrl_inst (
      .clk                 (clk),
      .rst                 (rst),
      .st_start            (st_start),
      .tile_clean          (tile_clean),
      .st_fifo_almost_full (st_fifo_almost_full),
      .bank_rd_data        (bank_rd_data),
      .rd_ena              (rd_ena),
      .rd_addr             (rd_addr),
      .st_fifo_push        (st_fifo_push),
      .st_fifo_data        (st_fifo_data),
      .st_done             (st_done)
   );

endmodule

`default_nettype wire

//--- ofm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_checker (
   input wire clk,
   input wire rst,
   input wire ld_fifo_empty,
   input wire ld_fifo_pop,
   input wire st_fifo_almost_full,
   input wire st_fifo_push,
   input wire ld_done,
   input wire st_done,
   input wire tile_clean
);
   // sticky per-rule failure flags
   logic pop_fail      = 1'b0;
   logic push_fail     = 1'b0;
   logic ld_hold_fail  = 1'b0;
   logic st_hold_fail  = 1'b0;
   logic failed;

   assign failed = pop_fail | push_fail | ld_hold_fail | st_hold_fail;

   // --------------------------------------------------
   // FIFO handshakes
   // --------------------------------------------------
   pop_not_empty: assert property (@(posedge clk) disable iff (rst)
      !(ld_fifo_pop && ld_fifo_empty))
   else begin
      pop_fail = 1'b1;
      $error("load FIFO popped while empty");
   end

   // two pushes may still drain after almost full, a third may not
   push_slack: assert property (@(posedge clk) disable iff (rst)
      $past(st_fifo_almost_full, 2) |-> !st_fifo_push)
   else begin
      push_fail = 1'b1;
      $error("store FIFO pushed more than 2 words after almost full");
   end

   // --------------------------------------------------
   // done flags are levels
   // --------------------------------------------------
   ld_done_hold: assert property (@(posedge clk) disable iff (rst)
      ($past(ld_done) && !$past(tile_clean)) |-> ld_done)
   else begin
      ld_hold_fail = 1'b1;
      $error("ld_done dropped without tile_clean");
   end

   st_done_hold: assert property (@(posedge clk) disable iff (rst)
      ($past(st_done) && !$past(tile_clean)) |-> st_done)
   else begin
      st_hold_fail = 1'b1;
      $error("st_done dropped without tile_clean");
   end

endmodule

bind ofm_buffer ofm_checker checker_inst (
   .clk                 (clk),
   .rst                 (rst),
   .ld_fifo_empty       (ld_fifo_empty),
   .ld_fifo_pop         (ld_fifo_pop),
   .st_fifo_almost_full (st_fifo_almost_full),
   .st_fifo_push        (st_fifo_push),
   .ld_done             (ld_done),
   .st_done             (st_done),
   .tile_clean          (tile_clean)
);

`default_nettype wire

//--- ofm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_tb;
   import ofm_pkg::*;

   localparam int N_ROWS   = 3;
   localparam int MAX_ACC  = 4;
   localparam int WAIT_MAX = 2000;  // cycles allowed per wait loop

   typedef struct packed {
      logic [BANK_W-1:0] bank;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] value;
   } acc_entry_t;

   typedef struct packed {
      logic [DATA_W-1:0]        base;     // loaded word k is base + k
      logic [2:0]               n_acc;
      acc_entry_t [MAX_ACC-1:0] acc;
      logic [6:0]               gap_pct;  // chance of an empty cycle
      logic [6:0]               af_pct;   // chance of almost full
   } tile_row_t;

   logic              clk;
   logic              rst;
   logic [DATA_W-1:0] ld_fifo_data        = '0;
   logic              ld_fifo_empty       = 1'b1;
   logic              st_fifo_almost_full = 1'b0;
   logic              ld_fifo_pop;
   logic [DATA_W-1:0] st_fifo_data;
   logic              st_fifo_push;
   logic              ld_start;
   logic              st_start;
   logic              tile_clean;
   logic              compute_start;
   logic              ld_done;
   logic              st_done;
   logic              compute_on_going;
   ofm_pe_req_t       pe_req;
   logic [DATA_W-1:0] pe_rd_data;

   logic [DATA_W-1:0] ld_q [$];            // load FIFO contents
   logic [DATA_W-1:0] st_q [$];            // words pushed by the DUT
   logic [DATA_W-1:0] tile_model [TILE_WORDS];
   logic              pop_seen;
   int                gap_pct = 0;
   int                af_pct  = 0;
   tile_row_t         rows [N_ROWS];

   ofm_buffer ofm_buffer_inst (
      .clk                 (clk),
      .rst                 (rst),
      .ld_fifo_data        (ld_fifo_data),
      .ld_fifo_empty       (ld_fifo_empty),
      .ld_fifo_pop         (ld_fifo_pop),
      .st_fifo_data        (st_fifo_data),
      .st_fifo_push        (st_fifo_push),
      .st_fifo_almost_full (st_fifo_almost_full),
      .ld_start            (ld_start),
      .st_start            (st_start),
      .tile_clean          (tile_clean),
      .compute_start       (compute_start),
      .ld_done             (ld_done),
      .st_done             (st_done),
      .compute_on_going    (compute_on_going),
      .pe_req              (pe_req),
      .pe_rd_data          (pe_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------------------------------------
   // FIFO models
   // --------------------------------------------------
   always @(posedge clk) begin
      pop_seen <= ld_fifo_pop;
      if (st_fifo_push)
         st_q.push_back(st_fifo_data);  // capture side of the store FIFO
   end

   always @(negedge clk) begin
      if (pop_seen) begin
         assert (ld_q.size() > 0)
         else abort_run("load FIFO popped with no words left");
         ld_fifo_data = ld_q.pop_front();  // one cycle after the pop
      end
      ld_fifo_empty       = (ld_q.size() == 0) || (int'($urandom % 100) < gap_pct);
      st_fifo_almost_full = int'($urandom % 100) < af_pct;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      assert (got === exp)
      else abort_run($sformatf("ERROR at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      assert (got === exp)
      else abort_run($sformatf("ERROR at %0t ns: %s got %b expected %b",
                               $time, name, got, exp));
   endtask

   task automatic wait_done(input logic store);
      int cycles = 0;
      while (!(store ? st_done : ld_done)) begin
         @(negedge clk);
         cycles++;
         assert (cycles <= WAIT_MAX)
         else abort_run(store ? "timeout waiting for st_done" : "timeout waiting for ld_done");
      end
   endtask

   task automatic wait_pushes(input int count);
      int cycles = 0;
      while (st_q.size() < count) begin
         @(negedge clk);
         cycles++;
         assert (cycles <= WAIT_MAX)
         else abort_run("timeout waiting for the store FIFO pushes");
      end
   endtask

   // rd strobe now, data expected at the next falling edge
   task automatic read_word(input logic [BANK_W-1:0] bank, input logic [ADDR_W-1:0] addr);
      int k;
      k = int'(bank) * SLICE_WORDS + int'(addr);
      pe_req      = '0;
      pe_req.rd   = 1'b1;
      pe_req.bank = bank;
      pe_req.addr = addr;
      @(negedge clk);
      pe_req = '0;
      check_word($sformatf("pe_rd_data[%0d]", k), pe_rd_data, tile_model[k]);
   endtask

   task automatic fill_table();
      rows[0]      = '0;               // plain load and store
      rows[0].base = 16'h0000;
      rows[1]        = '0;             // repeated address, wrap, stalls
      rows[1].base   = 16'h1000;
      rows[1].n_acc  = 3'd4;
      rows[1].acc[0] = '{2'd0, 4'd3, 16'd5};
      rows[1].acc[1] = '{2'd0, 4'd3, 16'd7};
      rows[1].acc[2] = '{2'd2, 4'd15, 16'hffff};
      rows[1].acc[3] = '{2'd3, 4'd0, 16'd100};
      rows[1].gap_pct = 7'd30;
      rows[1].af_pct  = 7'd40;
      rows[2]        = '0;             // second tile after clean, heavy stalls
      rows[2].base   = 16'hffe0;
      rows[2].n_acc  = 3'd2;
      rows[2].acc[0] = '{2'd1, 4'd8, 16'd9};
      rows[2].acc[1] = '{2'd1, 4'd8, 16'd1};
      rows[2].gap_pct = 7'd60;
      rows[2].af_pct  = 7'd70;
   endtask

   task automatic run_tile(input tile_row_t row);
      int         k;
      acc_entry_t e;
      st_q.delete();
      gap_pct = int'(row.gap_pct);
      af_pct  = int'(row.af_pct);
      for (k = 0; k < TILE_WORDS; k++) begin
         tile_model[k] = row.base + DATA_W'(k);
         ld_q.push_back(row.base + DATA_W'(k));
      end
      ld_start = 1'b1;
      @(negedge clk);
      ld_start = 1'b0;
      wait_done(1'b0);
      repeat (2) @(negedge clk);  // last bank write trails ld_done
      check_word("words left in load FIFO", DATA_W'(ld_q.size()), '0);

      // compute phase, a strobe before compute_start must be dropped
      pe_req = '{1'b1, 1'b0, 2'd0, 4'd0, 16'h5555};
      @(negedge clk);
      pe_req        = '0;
      compute_start = 1'b1;
      @(negedge clk);
      compute_start = 1'b0;
      check_flag("compute_on_going", compute_on_going, 1'b1);
      for (k = 0; k < int'(row.n_acc); k++) begin
         e = row.acc[k];
         pe_req = '{1'b1, 1'b0, e.bank, e.addr, e.value};
         tile_model[int'(e.bank) * SLICE_WORDS + int'(e.addr)] += e.value;
         @(negedge clk);
      end
      pe_req = '0;
      for (k = 0; k < int'(row.n_acc); k++)
         read_word(row.acc[k].bank, row.acc[k].addr);
      read_word(2'd0, 4'd0);
      read_word(2'd3, 4'd15);

      st_start = 1'b1;
      @(negedge clk);
      st_start = 1'b0;
      check_flag("compute_on_going", compute_on_going, 1'b0);
      wait_done(1'b1);
      wait_pushes(TILE_WORDS);
      repeat (4) @(negedge clk);  // room for any stray push
      check_word("store push count", DATA_W'(st_q.size()), DATA_W'(TILE_WORDS));
      for (k = 0; k < TILE_WORDS; k++)
         check_word($sformatf("st_fifo_data[%0d]", k), st_q[k], tile_model[k]);

      tile_clean = 1'b1;
      @(negedge clk);
      tile_clean = 1'b0;
      check_flag("ld_done", ld_done, 1'b0);
      check_flag("st_done", st_done, 1'b0);
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      void'($urandom(32'hec690e3d));
      rst           = 1'b1;
      ld_start      = 1'b0;
      st_start      = 1'b0;
      tile_clean    = 1'b0;
      compute_start = 1'b0;
      pe_req        = '0;
      fill_table();
      repeat (10) @(negedge clk);
      rst = 1'b0;
      check_flag("ld_fifo_pop", ld_fifo_pop, 1'b0);
      check_flag("st_fifo_push", st_fifo_push, 1'b0);
      check_flag("ld_done", ld_done, 1'b0);
      check_flag("st_done", st_done, 1'b0);
      check_flag("compute_on_going", compute_on_going, 1'b0);
      @(negedge clk);
      for (int r = 0; r < N_ROWS; r++)
         run_tile(rows[r]);
      if (!ofm_buffer_inst.checker_inst.failed) begin
         $display("TEST OK");
         $finish;
      end else begin
         abort_run("bound checker flagged a handshake violation");
      end
   end

endmodule

`default_nettype wire

//--- tb.f
ofm_pkg.sv
ofm_load_ctrl.sv
ofm_bank.sv
ofm_store_ctrl.sv
ofm_buffer.sv
ofm_checker.sv
ofm_tb.sv

//--- Makefile
TOP = ofm_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

# pass only when the pass line shows up in the log
run: compile
	rm -f run.log
	./obj_dir/sim | tee run.log
	grep -q "^TEST OK$$" run.log

clean:
	rm -rf obj_dir run.log
